//--- logic/mcu_pkg.sv
// mcu power and interrupt fabric shared definitions
// widths, vector types, interrupt bit positions and sequencer states
`default_nettype none

package mcu_pkg;

  // core interrupt vector and fast interrupt group
  typedef logic [31:0] irq_vec_t;
  typedef logic [14:0] fast_irq_t;

  // gpio split: pads 0..7 always-on, pads 8..31 in the peripheral domain
  localparam int NUM_GPIO_AO = 8;

  typedef logic [NUM_GPIO_AO-1:0] gpio_ao_t;
  typedef logic [23:0]            gpio_periph_t;
  typedef logic [31:0]            gpio_pad_t;

  // bit positions in irq_vec_t
  localparam int IRQ_SOFTWARE_BIT = 3;
  localparam int IRQ_TIMER_BIT    = 7;
  localparam int IRQ_EXTERNAL_BIT = 11;
  localparam int IRQ_FAST_LSB     = 16;

  // power-gating sequencer states, down path then up path
  typedef enum logic [3:0] {
    PWR_ON,
    PWR_GATE_CLK,
    PWR_ISOLATE,
    PWR_HOLD_RST,
    PWR_SWITCH_OFF,
    PWR_OFF,
    PWR_SWITCH_ON,
    PWR_RELEASE_RST,
    PWR_RELEASE_ISO
  } pwr_state_e;

endpackage

`default_nettype wire

//--- logic/domain_pwr_seq.sv
// power-gating sequencer for one switchable domain
// drives clock gate, isolation, reset and power switch, all active low
`timescale 1ns/1ps
`default_nettype none

module domain_pwr_seq (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic sleep_req_i,
  input  logic wake_i,
  input  logic switch_ack_ni,
  output logic clkgate_en_no,
  output logic iso_no,
  output logic rst_no,
  output logic switch_no
);

  mcu_pkg::pwr_state_e state_q;

  // a pending wake overrides the sleep request
  logic sleep_hold;

  assign sleep_hold = sleep_req_i && !wake_i;

  // outputs are registered and change together with the state
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q       <= mcu_pkg::PWR_ON;
      clkgate_en_no <= 1'b1;
      iso_no        <= 1'b1;
      rst_no        <= 1'b1;
      switch_no     <= 1'b1;
    end else begin
      case (state_q)
        mcu_pkg::PWR_ON: begin
          if (sleep_hold) begin
            clkgate_en_no <= 1'b0;
            state_q       <= mcu_pkg::PWR_GATE_CLK;
          end
        end

        // power down: clock, isolation, reset, then the switch
        mcu_pkg::PWR_GATE_CLK: begin
          iso_no  <= 1'b0;
          state_q <= mcu_pkg::PWR_ISOLATE;
        end

        mcu_pkg::PWR_ISOLATE: begin
          rst_no  <= 1'b0;
          state_q <= mcu_pkg::PWR_HOLD_RST;
        end

        mcu_pkg::PWR_HOLD_RST: begin
          // previous release phase must be acknowledged first
          if (switch_ack_ni) begin
            switch_no <= 1'b0;
            state_q   <= mcu_pkg::PWR_SWITCH_OFF;
          end
        end

        mcu_pkg::PWR_SWITCH_OFF: begin
          // wait for the switch to report the rail is off
          if (!switch_ack_ni) begin
            state_q <= mcu_pkg::PWR_OFF;
          end
        end

        mcu_pkg::PWR_OFF: begin
          if (!sleep_hold && !switch_ack_ni) begin
            switch_no <= 1'b1;
            state_q   <= mcu_pkg::PWR_SWITCH_ON;
          end
        end

        // power up in reverse order once the rail is back
        mcu_pkg::PWR_SWITCH_ON: begin
          if (switch_ack_ni) begin
            rst_no  <= 1'b1;
            state_q <= mcu_pkg::PWR_RELEASE_RST;
          end
        end

        mcu_pkg::PWR_RELEASE_RST: begin
          iso_no  <= 1'b1;
          state_q <= mcu_pkg::PWR_RELEASE_ISO;
        end

        mcu_pkg::PWR_RELEASE_ISO: begin
          clkgate_en_no <= 1'b1;
          state_q       <= mcu_pkg::PWR_ON;
        end

        default: begin
          // unused encodings fall back to the powered state
          state_q       <= mcu_pkg::PWR_ON;
          clkgate_en_no <= 1'b1;
          iso_no        <= 1'b1;
          rst_no        <= 1'b1;
          switch_no     <= 1'b1;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- logic/irq_assembler.sv
// interrupt assembler for the core
// packs the fast group and named sources into a registered vector plus wake flag
`timescale 1ns/1ps
`default_nettype none

module irq_assembler (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic [3:0]        rv_timer_intr_i,
  input  logic              irq_software_i,
  input  logic              irq_external_i,
  input  mcu_pkg::gpio_ao_t gpio_ao_intr_i,
  input  logic              spi_flash_intr_i,
  input  logic              spi_intr_i,
  input  logic              dma_done_intr_i,
  input  logic              accel_fast_intr_i,
  output mcu_pkg::irq_vec_t irq_o,
  output logic              wake_o
);

  localparam int FAST_W = $bits(mcu_pkg::fast_irq_t);

  mcu_pkg::fast_irq_t fast_irq;
  mcu_pkg::irq_vec_t  irq_d;

  // accelerator on top, timers 3..1 at the bottom
  assign fast_irq = {
    accel_fast_intr_i,
    gpio_ao_intr_i,
    spi_flash_intr_i,
    spi_intr_i,
    dma_done_intr_i,
    rv_timer_intr_i[3],
    rv_timer_intr_i[2],
    rv_timer_intr_i[1]
  };

  always_comb begin
    irq_d                                     = '0;
    irq_d[mcu_pkg::IRQ_SOFTWARE_BIT]          = irq_software_i;
    irq_d[mcu_pkg::IRQ_TIMER_BIT]             = rv_timer_intr_i[0];
    irq_d[mcu_pkg::IRQ_EXTERNAL_BIT]          = irq_external_i;
    irq_d[mcu_pkg::IRQ_FAST_LSB +: FAST_W]    = fast_irq;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      irq_o  <= '0;
      wake_o <= 1'b0;
    end else begin
      irq_o  <= irq_d;
      // any source wakes the cpu domain
      wake_o <= |irq_d;
    end
  end

endmodule

`default_nettype wire

//--- logic/gpio_pad_mux.sv
// gpio pad split between always-on and peripheral domains
// peripheral pads are clamped low while that domain is isolated
`timescale 1ns/1ps
`default_nettype none

module gpio_pad_mux (
  input  logic                  periph_iso_ni,
  input  mcu_pkg::gpio_ao_t     gpio_ao_out_i,
  input  mcu_pkg::gpio_ao_t     gpio_ao_oe_i,
  input  mcu_pkg::gpio_periph_t gpio_periph_out_i,
  input  mcu_pkg::gpio_periph_t gpio_periph_oe_i,
  input  mcu_pkg::gpio_pad_t    gpio_pad_i,
  output mcu_pkg::gpio_pad_t    gpio_pad_o,
  output mcu_pkg::gpio_pad_t    gpio_pad_oe_o,
  output mcu_pkg::gpio_ao_t     gpio_ao_in_o,
  output mcu_pkg::gpio_periph_t gpio_periph_in_o
);

  localparam int PAD_W    = $bits(mcu_pkg::gpio_pad_t);
  localparam int AO_W     = mcu_pkg::NUM_GPIO_AO;
  localparam int PERIPH_W = $bits(mcu_pkg::gpio_periph_t);

  mcu_pkg::gpio_periph_t iso_mask;

  // all ones while the peripheral domain is powered and not isolated
  assign iso_mask = {PERIPH_W{periph_iso_ni}};

  // pads 0..7 belong to the always-on domain
  assign gpio_pad_o[AO_W-1:0]    = gpio_ao_out_i;
  assign gpio_pad_oe_o[AO_W-1:0] = gpio_ao_oe_i;
  assign gpio_ao_in_o            = gpio_pad_i[AO_W-1:0];

  // pads 8..31 follow the peripheral gpio
  assign gpio_pad_o[PAD_W-1:AO_W]    = gpio_periph_out_i & iso_mask;
  assign gpio_pad_oe_o[PAD_W-1:AO_W] = gpio_periph_oe_i & iso_mask;

  // keep floating pad inputs out of the powered-down logic
  assign gpio_periph_in_o = gpio_pad_i[PAD_W-1:AO_W] & iso_mask;

endmodule

`default_nettype wire

//--- logic/mcu_pwr_top.sv
// mcu power-domain and interrupt fabric top level
// one sequencer per domain, interrupt assembly with cpu wake, gpio pad split
`timescale 1ns/1ps
`default_nettype none

module mcu_pwr_top #(
  parameter int NUM_BANKS = 2
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  dbg_reset_ni,
  input  logic                  core_sleep_i,
  input  logic                  periph_off_i,
  input  logic [NUM_BANKS-1:0]  bank_off_i,
  input  logic                  cpu_switch_ack_ni,
  input  logic                  periph_switch_ack_ni,
  input  logic [NUM_BANKS-1:0]  bank_switch_ack_ni,
  input  logic [3:0]            rv_timer_intr_i,
  input  logic                  irq_software_i,
  input  logic                  irq_external_i,
  input  mcu_pkg::gpio_ao_t     gpio_ao_intr_i,
  input  logic                  spi_flash_intr_i,
  input  logic                  spi_intr_i,
  input  logic                  dma_done_intr_i,
  input  logic                  accel_fast_intr_i,
  input  mcu_pkg::gpio_ao_t     gpio_ao_out_i,
  input  mcu_pkg::gpio_ao_t     gpio_ao_oe_i,
  input  mcu_pkg::gpio_periph_t gpio_periph_out_i,
  input  mcu_pkg::gpio_periph_t gpio_periph_oe_i,
  input  mcu_pkg::gpio_pad_t    gpio_pad_i,
  output logic                  cpu_clkgate_en_no,
  output logic                  cpu_iso_no,
  output logic                  cpu_rst_no,
  output logic                  cpu_switch_no,
  output logic                  periph_clkgate_en_no,
  output logic                  periph_iso_no,
  output logic                  periph_rst_no,
  output logic                  periph_switch_no,
  output logic [NUM_BANKS-1:0]  bank_clkgate_en_no,
  output logic [NUM_BANKS-1:0]  bank_iso_no,
  output logic [NUM_BANKS-1:0]  bank_rst_no,
  output logic [NUM_BANKS-1:0]  bank_switch_no,
  output mcu_pkg::irq_vec_t     irq_o,
  output mcu_pkg::gpio_pad_t    gpio_pad_o,
  output mcu_pkg::gpio_pad_t    gpio_pad_oe_o,
  output mcu_pkg::gpio_ao_t     gpio_ao_in_o,
  output mcu_pkg::gpio_periph_t gpio_periph_in_o
);

  // domain 0 is the cpu, 1 the peripherals, then the memory banks
  localparam int NUM_DOMAINS = 2 + NUM_BANKS;

  logic cpu_wake;

  logic [NUM_DOMAINS-1:0] dom_sleep_req;
  logic [NUM_DOMAINS-1:0] dom_wake;
  logic [NUM_DOMAINS-1:0] dom_switch_ack_n;
  logic [NUM_DOMAINS-1:0] dom_clkgate_en_n;
  logic [NUM_DOMAINS-1:0] dom_iso_n;
  logic [NUM_DOMAINS-1:0] dom_rst_n;
  logic [NUM_DOMAINS-1:0] dom_switch_n;

  assign dom_sleep_req    = {bank_off_i, periph_off_i, core_sleep_i};
  assign dom_switch_ack_n = {bank_switch_ack_ni, periph_switch_ack_ni, cpu_switch_ack_ni};
  // only the cpu has a wake source
  assign dom_wake         = {{(NUM_BANKS + 1){1'b0}}, cpu_wake};

  for (genvar d = 0; d < NUM_DOMAINS; d++) begin : g_domain
    domain_pwr_seq domain_pwr_seq_inst (
      .clk_i,
      .rst_n_i,
      .sleep_req_i  (dom_sleep_req[d]),
      .wake_i       (dom_wake[d]),
      .switch_ack_ni(dom_switch_ack_n[d]),
      .clkgate_en_no(dom_clkgate_en_n[d]),
      .iso_no       (dom_iso_n[d]),
      .rst_no       (dom_rst_n[d]),
      .switch_no    (dom_switch_n[d])
    );
  end

  assign cpu_clkgate_en_no = dom_clkgate_en_n[0];
  assign cpu_iso_no        = dom_iso_n[0];
  assign cpu_switch_no     = dom_switch_n[0];
  // debug system reset also holds the cpu and peripherals in reset
  assign cpu_rst_no        = dom_rst_n[0] & dbg_reset_ni;

  assign periph_clkgate_en_no = dom_clkgate_en_n[1];
  assign periph_iso_no        = dom_iso_n[1];
  assign periph_switch_no     = dom_switch_n[1];
  assign periph_rst_no        = dom_rst_n[1] & dbg_reset_ni;

  assign bank_clkgate_en_no = dom_clkgate_en_n[NUM_DOMAINS-1:2];
  assign bank_iso_no        = dom_iso_n[NUM_DOMAINS-1:2];
  assign bank_rst_no        = dom_rst_n[NUM_DOMAINS-1:2];
  assign bank_switch_no     = dom_switch_n[NUM_DOMAINS-1:2];

  irq_assembler irq_assembler_inst (
    .clk_i,
    .rst_n_i,
    .rv_timer_intr_i,
    .irq_software_i,
    .irq_external_i,
    .gpio_ao_intr_i,
    .spi_flash_intr_i,
    .spi_intr_i,
    .dma_done_intr_i,
    .accel_fast_intr_i,
    .irq_o,
    .wake_o(cpu_wake)
  );

  gpio_pad_mux gpio_pad_mux_inst (
    .periph_iso_ni(dom_iso_n[1]),
    .gpio_ao_out_i,
    .gpio_ao_oe_i,
    .gpio_periph_out_i,
    .gpio_periph_oe_i,
    .gpio_pad_i,
    .gpio_pad_o,
    .gpio_pad_oe_o,
    .gpio_ao_in_o,
    .gpio_periph_in_o
  );

endmodule

`default_nettype wire

//--- verification/mcu_pwr_checker.sv
// sequencing assertions for one power-gating sequencer
// bound into every domain_pwr_seq instance
`timescale 1ns/1ps
`default_nettype none

module mcu_pwr_checker (
  input logic                clk_i,
  input logic                rst_n_i,
  input logic                switch_ack_ni,
  input logic                clkgate_en_ni,
  input logic                iso_ni,
  input logic                rst_ni,
  input logic                switch_ni,
  input mcu_pkg::pwr_state_e state_i
);

  // switch opens only with clock gated, isolated and in reset
  switch_off_order: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $fell(switch_ni) |-> (!rst_ni && !iso_ni && !clkgate_en_ni))
    else $error("switch_no fell before the domain was gated, isolated and reset");

  // no PWR_OFF while the off request is still unacknowledged
  off_needs_ack: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (state_i == mcu_pkg::PWR_SWITCH_OFF && switch_ack_ni) |=> state_i != mcu_pkg::PWR_OFF)
    else $error("PWR_OFF entered before the switch ack");

  off_switch_low: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    state_i == mcu_pkg::PWR_OFF |-> !switch_ni)
    else $error("switch_no high in PWR_OFF");

  // release only after the off phase was acknowledged
  switch_on_after_ack: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(switch_ni) |-> $past(!switch_ack_ni))
    else $error("switch_no rose while the off ack was pending");

endmodule

bind domain_pwr_seq mcu_pwr_checker mcu_pwr_checker_inst (
  .clk_i        (clk_i),
  .rst_n_i      (rst_n_i),
  .switch_ack_ni(switch_ack_ni),
  .clkgate_en_ni(clkgate_en_no),
  .iso_ni       (iso_no),
  .rst_ni       (rst_no),
  .switch_ni    (switch_no),
  .state_i      (state_q)
);

`default_nettype wire

//--- verification/mcu_pwr_tb.sv
// testbench for the mcu power-domain and interrupt fabric
// table-driven domain requests, interrupt sources and gpio values
`timescale 1ns/1ps
`default_nettype none

module mcu_pwr_tb;

  localparam int NUM_BANKS = 2;
  localparam int NUM_DOM   = 2 + NUM_BANKS;
  localparam int MAX_ROWS  = 32;
  // longest row reverses a domain still waiting for its off ack
  localparam int SETTLE_CYCLES = 32;
  // every row plus the ordered peripheral run
  localparam int CYCLE_LIMIT = (MAX_ROWS + 2) * (SETTLE_CYCLES + 4);

  logic clk = 1'b0;
  logic rst_n = 1'b0;
  logic dbg_reset_n = 1'b1;
  logic [NUM_DOM-1:0] req = '0;
  // src: [3:0] timers, [4] sw, [5] ext, [13:6] gpio ao, [14] flash, [15] spi,
  // [16] dma, [17] accel
  logic [17:0] src = '0;
  mcu_pkg::gpio_ao_t     ao_out = '0;
  mcu_pkg::gpio_ao_t     ao_oe = '0;
  mcu_pkg::gpio_periph_t p_out = '0;
  mcu_pkg::gpio_periph_t p_oe = '0;
  mcu_pkg::gpio_pad_t    pad_in = '0;
  int cycles = 0;

  wire [NUM_DOM-1:0] sw_n;
  wire [NUM_DOM-1:0] ack_n;
  logic cpu_cg_n, cpu_iso_n, cpu_rst_n, cpu_sw_n;
  logic per_cg_n, per_iso_n, per_rst_n, per_sw_n;
  logic [NUM_BANKS-1:0] bank_cg_n, bank_iso_n, bank_rst_n, bank_sw_n;
  mcu_pkg::irq_vec_t     irq;
  mcu_pkg::gpio_pad_t    pad_out, pad_oe;
  mcu_pkg::gpio_ao_t     ao_in;
  mcu_pkg::gpio_periph_t p_in;

  string                 row_name[MAX_ROWS];
  logic [NUM_DOM-1:0]    row_req[MAX_ROWS];
  logic                  row_dbg_n[MAX_ROWS];
  logic [17:0]           row_src[MAX_ROWS];
  logic [NUM_DOM-1:0]    row_on[MAX_ROWS];
  mcu_pkg::gpio_ao_t     row_ao_out[MAX_ROWS];
  mcu_pkg::gpio_ao_t     row_ao_oe[MAX_ROWS];
  mcu_pkg::gpio_periph_t row_p_out[MAX_ROWS];
  mcu_pkg::gpio_periph_t row_p_oe[MAX_ROWS];
  mcu_pkg::gpio_pad_t    row_pad_in[MAX_ROWS];
  int n_rows = 0;

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > CYCLE_LIMIT) begin
      $display("timeout after %0d cycles waiting for the power sequencers", cycles);
      $display("TESTS FAILED");
      $fatal(1);
    end
  end

  assign sw_n = {bank_sw_n, per_sw_n, cpu_sw_n};

  // switch models answer each switch edge after 1 to 5 cycles
  for (genvar d = 0; d < NUM_DOM; d++) begin : g_switch
    logic ack_q = 1'b1;
    assign ack_n[d] = ack_q;
    always begin
      @(sw_n[d]);
      repeat (1 + ($urandom % 5)) @(posedge clk);
      #1 ack_q = sw_n[d];
    end
  end

  mcu_pwr_top #(.NUM_BANKS(NUM_BANKS)) mcu_pwr_top_inst (
    .clk_i(clk), .rst_n_i(rst_n), .dbg_reset_ni(dbg_reset_n),
    .core_sleep_i(req[0]), .periph_off_i(req[1]), .bank_off_i(req[NUM_DOM-1:2]),
    .cpu_switch_ack_ni(ack_n[0]), .periph_switch_ack_ni(ack_n[1]),
    .bank_switch_ack_ni(ack_n[NUM_DOM-1:2]),
    .rv_timer_intr_i(src[3:0]), .irq_software_i(src[4]), .irq_external_i(src[5]),
    .gpio_ao_intr_i(src[13:6]), .spi_flash_intr_i(src[14]), .spi_intr_i(src[15]),
    .dma_done_intr_i(src[16]), .accel_fast_intr_i(src[17]),
    .gpio_ao_out_i(ao_out), .gpio_ao_oe_i(ao_oe),
    .gpio_periph_out_i(p_out), .gpio_periph_oe_i(p_oe), .gpio_pad_i(pad_in),
    .cpu_clkgate_en_no(cpu_cg_n), .cpu_iso_no(cpu_iso_n),
    .cpu_rst_no(cpu_rst_n), .cpu_switch_no(cpu_sw_n),
    .periph_clkgate_en_no(per_cg_n), .periph_iso_no(per_iso_n),
    .periph_rst_no(per_rst_n), .periph_switch_no(per_sw_n),
    .bank_clkgate_en_no(bank_cg_n), .bank_iso_no(bank_iso_n),
    .bank_rst_no(bank_rst_n), .bank_switch_no(bank_sw_n),
    .irq_o(irq), .gpio_pad_o(pad_out), .gpio_pad_oe_o(pad_oe),
    .gpio_ao_in_o(ao_in), .gpio_periph_in_o(p_in)
  );

  task automatic report_mismatch(input string name, input string what,
                                 input logic [31:0] exp, input logic [31:0] act);
    $display("ERROR %s %s expected %h actual %h", name, what, exp, act);
    $display("TESTS FAILED");
    $fatal(1);
  endtask

  task automatic check_irq(input string name, input mcu_pkg::irq_vec_t exp,
                           input mcu_pkg::irq_vec_t act);
    if (act !== exp) report_mismatch(name, "irq_o", exp, act);
  endtask

  task automatic check_pads(input string name, input string what,
                            input mcu_pkg::gpio_pad_t exp, input mcu_pkg::gpio_pad_t act);
    if (act !== exp) report_mismatch(name, what, exp, act);
  endtask

  task automatic check_ctrl(input string name, input logic [3:0] exp, input logic [3:0] act);
    if (act !== exp) report_mismatch(name, "ctrl", {28'd0, exp}, {28'd0, act});
  endtask

  // {clkgate, iso, rst, switch} of one domain
  function automatic logic [3:0] dom_ctrl(input int d);
    case (d)
      0: dom_ctrl = {cpu_cg_n, cpu_iso_n, cpu_rst_n, cpu_sw_n};
      1: dom_ctrl = {per_cg_n, per_iso_n, per_rst_n, per_sw_n};
      default: dom_ctrl = {bank_cg_n[d-2], bank_iso_n[d-2], bank_rst_n[d-2], bank_sw_n[d-2]};
    endcase
  endfunction

  function automatic logic [3:0] expected_ctrl(input int d, input logic on, input logic dbg_n);
    if (!on) expected_ctrl = 4'b0000;
    else if (d < 2) expected_ctrl = {2'b11, dbg_n, 1'b1};
    else expected_ctrl = 4'b1111;
  endfunction

  function automatic mcu_pkg::irq_vec_t expected_irq(input logic [17:0] s);
    mcu_pkg::irq_vec_t v;
    v = '0;
    v[mcu_pkg::IRQ_SOFTWARE_BIT] = s[4];
    v[mcu_pkg::IRQ_TIMER_BIT] = s[0];
    v[mcu_pkg::IRQ_EXTERNAL_BIT] = s[5];
    v[18:16] = s[3:1];
    v[19] = s[16];
    v[20] = s[15];
    v[21] = s[14];
    v[29:22] = s[13:6];
    v[30] = s[17];
    return v;
  endfunction

  task automatic add_row(input string name, input logic [NUM_DOM-1:0] r, input logic dbg_n,
                         input logic [17:0] s, input logic [NUM_DOM-1:0] on);
    logic [31:0] a;
    logic [31:0] b;
    a = $urandom;
    b = $urandom;
    row_name[n_rows] = name;
    row_req[n_rows] = r;
    row_dbg_n[n_rows] = dbg_n;
    row_src[n_rows] = s;
    row_on[n_rows] = on;
    row_ao_out[n_rows] = a[7:0];
    row_ao_oe[n_rows] = b[7:0];
    row_p_out[n_rows] = a[31:8];
    row_p_oe[n_rows] = b[31:8];
    row_pad_in[n_rows] = a ^ b;
    n_rows++;
  endtask

  function automatic logic settled(input int i);
    logic ok;
    ok = 1'b1;
    for (int d = 0; d < NUM_DOM; d++)
      if (dom_ctrl(d) !== expected_ctrl(d, row_on[i][d], row_dbg_n[i])) ok = 1'b0;
    return ok;
  endfunction

  task automatic apply_row(input int i);
    mcu_pkg::gpio_periph_t mask;
    @(posedge clk);
    #1;
    req = row_req[i];
    dbg_reset_n = row_dbg_n[i];
    src = row_src[i];
    ao_out = row_ao_out[i];
    ao_oe = row_ao_oe[i];
    p_out = row_p_out[i];
    p_oe = row_p_oe[i];
    pad_in = row_pad_in[i];
    @(posedge clk);
    #1;
    check_irq(row_name[i], expected_irq(row_src[i]), irq);
    // sequencers get a bounded number of cycles to reach the row's state
    for (int w = 0; w < SETTLE_CYCLES && !settled(i); w++) begin
      @(posedge clk);
      #1;
    end
    for (int d = 0; d < NUM_DOM; d++)
      check_ctrl(row_name[i], expected_ctrl(d, row_on[i][d], row_dbg_n[i]), dom_ctrl(d));
    mask = {24{row_on[i][1]}};
    check_pads(row_name[i], "pad_o", {row_p_out[i] & mask, row_ao_out[i]}, pad_out);
    check_pads(row_name[i], "pad_oe", {row_p_oe[i] & mask, row_ao_oe[i]}, pad_oe);
    check_pads(row_name[i], "pad_in", {row_pad_in[i][31:8] & mask, row_pad_in[i][7:0]},
               {p_in, ao_in});
  endtask

  // cycle-exact peripheral down and up order
  task automatic run_periph_order();
    logic [3:0] down_exp[4];
    down_exp = '{4'b0111, 4'b0011, 4'b0001, 4'b0000};
    @(posedge clk);
    #1 req = 4'b0010;
    for (int k = 0; k < 4; k++) begin
      @(posedge clk);
      #1 check_ctrl("periph_order_down", down_exp[k], dom_ctrl(1));
    end
    while (ack_n[1]) begin
      @(posedge clk);
      #1 check_ctrl("periph_hold_off", 4'b0000, dom_ctrl(1));
    end
    repeat (3) @(posedge clk);
    #1 check_ctrl("periph_off", 4'b0000, dom_ctrl(1));
    req = 4'b0000;
    @(posedge clk);
    #1 check_ctrl("periph_order_switch", 4'b0001, dom_ctrl(1));
    // reset released on the edge that samples the on ack
    @(posedge ack_n[1]);
    @(posedge clk);
    #1 check_ctrl("periph_order_rst", 4'b0011, dom_ctrl(1));
    @(posedge clk);
    #1 check_ctrl("periph_order_iso", 4'b0111, dom_ctrl(1));
    @(posedge clk);
    #1 check_ctrl("periph_order_clk", 4'b1111, dom_ctrl(1));
  endtask

  initial begin
    void'($urandom(10293));
    add_row("reset_idle", 4'b0000, 1'b1, '0, 4'b1111);
    for (int b = 0; b < 18; b++) begin
      add_row($sformatf("irq_src_%0d", b), 4'b0000, 1'b1, 18'(1) << b, 4'b1111);
    end
    add_row("periph_off", 4'b0010, 1'b1, '0, 4'b1101);
    add_row("periph_on", 4'b0000, 1'b1, '0, 4'b1111);
    add_row("cpu_sleep", 4'b0001, 1'b1, '0, 4'b1110);
    add_row("cpu_wake_irq", 4'b0001, 1'b1, 18'h00010, 4'b1111);
    add_row("cpu_awake", 4'b0000, 1'b1, '0, 4'b1111);
    add_row("bank0_off", 4'b0100, 1'b1, '0, 4'b1011);
    add_row("banks_off", 4'b1100, 1'b1, '0, 4'b0011);
    add_row("bank1_only_off", 4'b1000, 1'b1, '0, 4'b0111);
    add_row("banks_on", 4'b0000, 1'b1, '0, 4'b1111);
    add_row("dbg_reset", 4'b0000, 1'b0, '0, 4'b1111);
    add_row("dbg_release", 4'b0000, 1'b1, '0, 4'b1111);

    repeat (3) @(posedge clk);
    #1 rst_n = 1'b1;
    check_irq("after_reset", '0, irq);
    for (int d = 0; d < NUM_DOM; d++) check_ctrl("after_reset", 4'b1111, dom_ctrl(d));
    for (int i = 0; i < n_rows; i++) apply_row(i);
    run_periph_order();
    $display("TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
logic/mcu_pkg.sv
logic/domain_pwr_seq.sv
logic/irq_assembler.sv
logic/gpio_pad_mux.sv
logic/mcu_pwr_top.sv
verification/mcu_pwr_checker.sv
verification/mcu_pwr_tb.sv

//--- Makefile
# Verilator flow for the mcu power and interrupt fabric

VERILATOR  ?= verilator
TOP        ?= mcu_pwr_tb
FLIST      ?= flist.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --timing --assert
LINT_FLAGS ?= --lint-only --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FLIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(shell cat $(FLIST))
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then \
	  echo "simulation failed"; exit 1; \
	elif ! grep -q "TESTS PASSED" $(LOG); then \
	  echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
